// ==== logic/hispi_pkg.sv ====
package hispi_pkg;

    localparam int NUM_LANES  = 4;    // serial lanes per sensor port
    localparam int WORD_W     = 12;   // pixel and code word width
    localparam int NIB_W      = 4;    // bits per lane per enabled cycle
    localparam int FIFO_DEPTH = 8;    // default words per lane fifo
    localparam int LANE_WAIT  = 8;    // default cycles allowed between first and last lane sol
    localparam bit MSB_FIRST  = 1'b0; // default bit order within a nibble
    localparam int EMBED_BIT  = 8;    // code word flag for embedded-data lines

    typedef logic [WORD_W-1:0] pixel_t;

    // sync prefix is one all-ones word then two all-zero words
    localparam pixel_t SYNC_ONES  = '1;
    localparam pixel_t SYNC_ZEROS = '0;

    typedef enum logic [2:0] {
        SC_SOL,  // start of line
        SC_SOF,  // start of frame, also starts a line
        SC_EOL,  // end of line
        SC_EOF,  // end of frame, also ends a line
        SC_NONE  // not a known code
    } sync_code_e;

    typedef enum logic [1:0] {
        LS_HUNT,   // searching for the all-ones word
        LS_ZERO1,  // expecting first zero word
        LS_ZERO2,  // expecting second zero word
        LS_CODE    // locked, code word then payload
    } lane_state_e;

    // kind of a code word from its low nibble
    function automatic sync_code_e code_of(pixel_t w);
        case (w[3:0])
            4'h1:    return SC_SOL;
            4'h3:    return SC_SOF;
            4'h5:    return SC_EOL;
            4'h7:    return SC_EOF;
            default: return SC_NONE;
        endcase
    endfunction

endpackage

// ==== logic/hispi_word_if.sv ====
interface hispi_word_if;
    import hispi_pkg::*;

    pixel_t word;  // aligned pixel word, valid with dv
    logic   dv;    // pixel strobe
    logic   sol;   // start of line code seen
    logic   eol;   // end of line code seen
    logic   sof;   // start of frame code seen
    logic   eof;   // end of frame code seen
    logic   embed; // code word flagged embedded data

    modport dec (
        output word, dv, sol, eol, sof, eof, embed
    );

    modport fifo (
        input word, dv, sol, eol, sof, eof, embed
    );

endinterface

// ==== logic/hispi_lane_decoder.sv ====
module hispi_lane_decoder #(
    parameter bit MSB_FIRST = hispi_pkg::MSB_FIRST
) (
    input  logic                        ipclk,
    input  logic                        prst,
    input  logic                        sns_en,
    input  logic [hispi_pkg::NIB_W-1:0] din,
    hispi_word_if.dec                   word_o
);
    import hispi_pkg::*;

    localparam int           WIN_W   = WORD_W + NIB_W;        // room for every bit offset
    localparam logic [1:0]   PH_LAST = 2'(WORD_W / NIB_W - 1); // nibbles per word minus one

    lane_state_e      state;
    sync_code_e       code;      // class of the word completing now
    logic [WIN_W-1:0] win;       // recent bits, earliest at msb
    logic [WIN_W-1:0] win_nxt;
    logic [NIB_W-1:0] nib;       // incoming nibble in time order
    pixel_t           slice;     // window bits at the locked offset
    pixel_t           word_cur;  // slice in word bit order
    logic [2:0]       off;       // locked offset, 1..NIB_W
    logic [2:0]       hit_off;
    logic             hit;
    logic [1:0]       ph;        // nibble phase within a word
    logic             done;      // word completes this cycle
    logic             code_next; // next word is the code word
    logic             in_line;   // between sol and eol

    always_comb begin
        for (int b = 0; b < NIB_W; b++) begin
            nib[b] = MSB_FIRST ? din[b] : din[NIB_W-1-b];
        end
        win_nxt = {win[WIN_W-NIB_W-1:0], nib};
        slice   = win_nxt[off +: WORD_W];
        for (int b = 0; b < WORD_W; b++) begin
            word_cur[b] = MSB_FIRST ? slice[b] : slice[WORD_W-1-b];
        end
        // ones word must be followed by a zero bit, pins the exact boundary
        hit     = 1'b0;
        hit_off = 3'd1;
        for (int o = 1; o <= NIB_W; o++) begin
            if (win_nxt[o +: WORD_W] == SYNC_ONES && !win_nxt[o-1]) begin
                hit     = 1'b1;
                hit_off = 3'(o);
            end
        end
        code = code_of(word_cur);
        done = sns_en && (ph == PH_LAST);
    end

    always_ff @(posedge ipclk) begin
        if (sns_en) win <= win_nxt; // bit history, no reset
        if (done)   word_o.word <= word_cur;
    end

    always_ff @(posedge ipclk) begin
        if (prst) begin
            state        <= LS_HUNT;
            off          <= 3'd1;
            ph           <= '0;
            code_next    <= 1'b0;
            in_line      <= 1'b0;
            word_o.dv    <= 1'b0;
            word_o.sol   <= 1'b0;
            word_o.eol   <= 1'b0;
            word_o.sof   <= 1'b0;
            word_o.eof   <= 1'b0;
            word_o.embed <= 1'b0;
        end else begin
            word_o.dv    <= 1'b0; // all outputs are one-cycle strobes
            word_o.sol   <= 1'b0;
            word_o.eol   <= 1'b0;
            word_o.sof   <= 1'b0;
            word_o.eof   <= 1'b0;
            word_o.embed <= 1'b0;
            if (sns_en) ph <= (ph == PH_LAST) ? '0 : ph + 2'd1;
            case (state)
                LS_HUNT: if (sns_en && hit) begin
                    off   <= hit_off; // lock offset, word phase restarts
                    ph    <= '0;
                    state <= LS_ZERO1;
                end
                LS_ZERO1: if (done) begin
                    state <= (word_cur == SYNC_ZEROS) ? LS_ZERO2 : LS_HUNT;
                end
                LS_ZERO2: if (done) begin
                    state     <= (word_cur == SYNC_ZEROS) ? LS_CODE : LS_HUNT;
                    code_next <= 1'b1;
                end
                LS_CODE: if (done) begin
                    if (code_next) begin
                        code_next    <= 1'b0;
                        word_o.embed <= word_cur[EMBED_BIT];
                        case (code)
                            SC_SOL: begin
                                word_o.sol <= 1'b1;
                                in_line    <= 1'b1;
                            end
                            SC_SOF: begin
                                word_o.sof <= 1'b1;
                                in_line    <= 1'b1;
                            end
                            SC_EOL: begin
                                word_o.eol <= 1'b1;
                                in_line    <= 1'b0;
                            end
                            SC_EOF: begin
                                word_o.eof <= 1'b1;
                                in_line    <= 1'b0;
                            end
                            default: in_line <= 1'b0; // unknown code, drop payload
                        endcase
                    end else if (word_cur == SYNC_ONES) begin
                        state <= LS_ZERO1; // next prefix, offset kept
                    end else if (in_line) begin
                        word_o.dv <= 1'b1;
                    end
                end
                default: state <= LS_HUNT;
            endcase
        end
    end

    a_one_marker: assert property (@(posedge ipclk) disable iff (prst)
        $onehot0({word_o.dv, word_o.sol, word_o.eol, word_o.sof, word_o.eof}));

endmodule

// ==== logic/hispi_line_fifo.sv ====
module hispi_line_fifo #(
    parameter int FIFO_DEPTH = hispi_pkg::FIFO_DEPTH
) (
    input  logic              ipclk,
    input  logic              prst,
    input  logic              ignore_embedded,
    hispi_word_if.fifo        word_i,
    input  logic              rd,
    input  logic              flush,
    output logic              line_ready,
    output logic              empty,
    output logic              eol_head,
    output hispi_pkg::pixel_t head_word
);
    import hispi_pkg::*;

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    pixel_t                mem_word [FIFO_DEPTH];
    logic [FIFO_DEPTH-1:0] mem_eol;  // tag on the last word of a line
    logic [AW-1:0]         wr_ptr;
    logic [AW-1:0]         rd_ptr;
    logic [AW-1:0]         last_ptr; // most recent write
    logic [AW:0]           count;
    logic [AW:0]           pending;  // lines with words still held
    logic                  wr_line;  // accepting the current line
    logic                  wr_first; // no word of the line written yet
    logic                  line_sol;
    logic                  line_eol;
    logic                  wr_en;
    logic                  full;
    logic                  rd_eol;

    function automatic logic [AW-1:0] ptr_inc(logic [AW-1:0] p);
        return (p == AW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_comb begin
        line_sol   = word_i.sol | word_i.sof;
        line_eol   = word_i.eol | word_i.eof;
        wr_en      = word_i.dv & wr_line;
        full       = (count == (AW+1)'(FIFO_DEPTH));
        // last word held back until its eol tag is known
        empty      = (count == '0) || (wr_line && !wr_first && count == (AW+1)'(1));
        line_ready = (pending != '0) && !empty;
        head_word  = mem_word[rd_ptr];
        eol_head   = mem_eol[rd_ptr];
        rd_eol     = rd & eol_head;
    end

    always_ff @(posedge ipclk) begin
        if (wr_en) begin
            mem_word[wr_ptr] <= word_i.word;
            mem_eol[wr_ptr]  <= 1'b0;
        end
        if (line_eol && wr_line && !wr_first) mem_eol[last_ptr] <= 1'b1;
    end

    always_ff @(posedge ipclk) begin
        if (prst || flush) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            last_ptr <= '0;
            count    <= '0;
            pending  <= '0;
            wr_line  <= 1'b0; // rest of a flushed line is dropped
            wr_first <= 1'b0;
        end else begin
            if (line_sol) begin
                wr_line  <= !(ignore_embedded && word_i.embed);
                wr_first <= 1'b1;
            end else if (line_eol) begin
                wr_line <= 1'b0;
            end
            if (wr_en) begin
                wr_ptr   <= ptr_inc(wr_ptr);
                last_ptr <= wr_ptr;
                wr_first <= 1'b0;
            end
            if (rd) rd_ptr <= ptr_inc(rd_ptr);
            count   <= count + (AW+1)'(wr_en) - (AW+1)'(rd);
            pending <= pending + (AW+1)'(wr_en & wr_first) - (AW+1)'(rd_eol); // empty lines leave no count
        end
    end

    a_no_overflow: assert property (@(posedge ipclk) disable iff (prst)
        wr_en |-> !full);

endmodule

// ==== logic/hispi_lane_merge.sv ====
module hispi_lane_merge #(
    parameter int LANE_WAIT = hispi_pkg::LANE_WAIT
) (
    input  logic                                           ipclk,
    input  logic                                           prst,
    input  logic [hispi_pkg::NUM_LANES-1:0]                line_ready,
    input  logic [hispi_pkg::NUM_LANES-1:0]                empty,
    input  logic [hispi_pkg::NUM_LANES-1:0]                eol_head,
    input  hispi_pkg::pixel_t [hispi_pkg::NUM_LANES-1:0]   head_word,
    output logic [hispi_pkg::NUM_LANES-1:0]                rd,
    output logic [hispi_pkg::NUM_LANES-1:0]                flush,
    output logic                                           pix_valid,
    output logic                                           line_start,
    output logic                                           line_done,
    output logic                                           line_err,
    output hispi_pkg::pixel_t                              pix_word
);
    import hispi_pkg::*;

    localparam int            PW   = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int            CW   = $clog2(LANE_WAIT + 1);
    localparam logic [PW-1:0] LAST = PW'(NUM_LANES - 1);

    logic          active;   // line being read out
    logic          first;    // next read is the first pixel
    logic [PW-1:0] ptr;      // lane in turn
    logic [CW-1:0] wait_cnt; // cycles since first lane became ready
    logic          all_ready;
    logic          waiting;
    logic          expire;

    always_comb begin
        all_ready  = &line_ready;
        waiting    = !active && (|line_ready) && !all_ready;
        expire     = waiting && (wait_cnt == CW'(LANE_WAIT - 1));
        rd         = '0;
        if (active && !empty[ptr]) rd[ptr] = 1'b1; // empty lane holds the turn
        pix_valid  = |rd;
        pix_word   = head_word[ptr];
        line_start = pix_valid && first;
        line_done  = rd[LAST] && eol_head[LAST]; // last lane closes the line
        flush      = {NUM_LANES{expire}};
    end

    always_ff @(posedge ipclk) begin
        if (prst) begin
            active   <= 1'b0;
            first    <= 1'b0;
            ptr      <= '0;
            wait_cnt <= '0;
            line_err <= 1'b0;
        end else begin
            line_err <= expire; // one pulse per dropped line
            if (!active) begin
                ptr <= '0;
                if (all_ready) begin
                    active <= 1'b1;
                    first  <= 1'b1;
                end
            end else if (pix_valid) begin
                first <= 1'b0;
                ptr   <= (ptr == LAST) ? '0 : ptr + 1'b1;
                if (line_done) active <= 1'b0;
            end
            if (waiting && !expire) wait_cnt <= wait_cnt + 1'b1;
            else                    wait_cnt <= '0;
        end
    end

    // reads go to a single lane and never race a flush
    a_rd_onehot: assert property (@(posedge ipclk) disable iff (prst)
        $onehot0(rd) && ((rd & flush) == '0));

endmodule

// ==== logic/hispi_pixel_out.sv ====
module hispi_pixel_out (
    input  logic              ipclk,
    input  logic              prst,
    input  logic              pix_valid,
    input  logic              line_start,
    input  logic              line_done,
    input  logic              frame_start,
    input  logic              frame_end,
    input  hispi_pkg::pixel_t pix_word,
    output hispi_pkg::pixel_t pxd,
    output logic              hact,
    output logic              vact,
    output logic [11:0]       line_num
);
    logic in_line;  // merge is emitting a line
    logic eof_pend; // frame ended, waiting for the line to drain

    always_ff @(posedge ipclk) begin
        if (pix_valid) pxd <= pix_word;
    end

    always_ff @(posedge ipclk) begin
        if (prst) begin
            hact     <= 1'b0;
            vact     <= 1'b0;
            in_line  <= 1'b0;
            eof_pend <= 1'b0;
            line_num <= '0;
        end else begin
            hact <= pix_valid; // aligned with pxd
            if (line_start)     in_line <= 1'b1;
            else if (line_done) in_line <= 1'b0;
            if (frame_start) begin
                vact     <= 1'b1;
                eof_pend <= 1'b0;
                line_num <= '0;
            end else begin
                if (frame_end) eof_pend <= 1'b1;
                if (eof_pend && !in_line && !line_start) begin
                    vact     <= 1'b0; // falls with hact after the last pixel
                    eof_pend <= 1'b0;
                end
                if (line_done) line_num <= line_num + 12'd1;
            end
        end
    end

endmodule

// ==== logic/hispi_rx_top.sv ====
module hispi_rx_top #(
    parameter int FIFO_DEPTH = hispi_pkg::FIFO_DEPTH,
    parameter int LANE_WAIT  = hispi_pkg::LANE_WAIT,
    parameter bit MSB_FIRST  = hispi_pkg::MSB_FIRST
) (
    input  logic                                            ipclk,
    input  logic                                            prst,
    input  logic                                            sns_en,
    input  logic [hispi_pkg::NUM_LANES*hispi_pkg::NIB_W-1:0] sns_d,
    input  logic                                            ignore_embedded,
    output logic [hispi_pkg::WORD_W-1:0]                    pxd,
    output logic                                            hact,
    output logic                                            vact,
    output logic [11:0]                                     line_num,
    output logic                                            line_err
);
    import hispi_pkg::*;

    logic [NUM_LANES-1:0] line_ready;
    logic [NUM_LANES-1:0] empty;
    logic [NUM_LANES-1:0] eol_head;
    logic [NUM_LANES-1:0] rd;
    logic [NUM_LANES-1:0] flush;
    pixel_t [NUM_LANES-1:0] head_word;
    pixel_t               pix_word;
    logic                 pix_valid;
    logic                 line_start;
    logic                 line_done;
    logic                 frame_start; // frame markers follow lane 0
    logic                 frame_end;

    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
        hispi_word_if u_wif ();

        hispi_lane_decoder #(
            .MSB_FIRST (MSB_FIRST)
        ) u_dec (
            .ipclk  (ipclk),
            .prst   (prst),
            .sns_en (sns_en),
            .din    (sns_d[i*NIB_W +: NIB_W]),
            .word_o (u_wif)
        );

        hispi_line_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_fifo (
            .ipclk           (ipclk),
            .prst            (prst),
            .ignore_embedded (ignore_embedded),
            .word_i          (u_wif),
            .rd              (rd[i]),
            .flush           (flush[i]),
            .line_ready      (line_ready[i]),
            .empty           (empty[i]),
            .eol_head        (eol_head[i]),
            .head_word       (head_word[i])
        );

        if (i == 0) begin : gen_frame
            assign frame_start = u_wif.sof;
            assign frame_end   = u_wif.eof;
        end
    end

    hispi_lane_merge #(
        .LANE_WAIT (LANE_WAIT)
    ) u_merge (
        .ipclk      (ipclk),
        .prst       (prst),
        .line_ready (line_ready),
        .empty      (empty),
        .eol_head   (eol_head),
        .head_word  (head_word),
        .rd         (rd),
        .flush      (flush),
        .pix_valid  (pix_valid),
        .line_start (line_start),
        .line_done  (line_done),
        .line_err   (line_err),
        .pix_word   (pix_word)
    );

    hispi_pixel_out u_out (
        .ipclk       (ipclk),
        .prst        (prst),
        .pix_valid   (pix_valid),
        .line_start  (line_start),
        .line_done   (line_done),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .pix_word    (pix_word),
        .pxd         (pxd),
        .hact        (hact),
        .vact        (vact),
        .line_num    (line_num)
    );

endmodule

// ==== verification/hispi_sensor_model.sv ====
module hispi_sensor_model #(
    parameter bit MSB_FIRST = hispi_pkg::MSB_FIRST
) (
    input  logic                                             ipclk,
    output logic                                             sns_en,
    output logic [hispi_pkg::NUM_LANES*hispi_pkg::NIB_W-1:0] sns_d
);
    import hispi_pkg::*;

    localparam int LINE_W = 8; // pixels per sensor line

    bit lane_q [NUM_LANES][$]; // serial bits per lane, earliest first
    int cyc;                   // cycle count for the enable gaps

    initial begin
        sns_en = 1'b0;
        sns_d  = '0;
        cyc    = 0;
    end

    task automatic clear();
        for (int l = 0; l < NUM_LANES; l++) lane_q[l].delete();
    endtask

    task automatic push_word(input int lane, input pixel_t w);
        for (int b = 0; b < WORD_W; b++) begin
            lane_q[lane].push_back(MSB_FIRST ? w[WORD_W-1-b] : w[b]); // bit order on the wire
        end
    endtask

    task automatic push_prefix(input int lane);
        push_word(lane, SYNC_ONES);
        push_word(lane, SYNC_ZEROS);
        push_word(lane, SYNC_ZEROS);
    endtask

    // idle zeros ahead of the first sync give skew and bit offset
    task automatic lead_in(input int lane, input int nibs, input int bits);
        repeat (nibs * NIB_W + bits) lane_q[lane].push_back(1'b0);
    endtask

    // pixel k goes to lane k mod 4, a missing lane sends idle words instead of its sol
    task automatic add_line(input pixel_t pix [LINE_W], input pixel_t sol, input pixel_t eol,
                            input int miss_lane);
        for (int l = 0; l < NUM_LANES; l++) begin
            if (l == miss_lane) begin
                repeat (4) push_word(l, SYNC_ZEROS);
            end else begin
                push_prefix(l);
                push_word(l, sol);
            end
            for (int k = l; k < LINE_W; k += NUM_LANES) push_word(l, pix[k]);
            push_prefix(l);
            push_word(l, eol);
        end
    endtask

    // any random bits, no sync framing
    task automatic add_bit(input int lane, input bit b);
        lane_q[lane].push_back(b);
    endtask

    // serialise all lanes, one nibble per enabled cycle, gap every fourth cycle
    task automatic play();
        int len;
        logic [NUM_LANES*NIB_W-1:0] d;
        len = 0;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (lane_q[l].size() > len) len = lane_q[l].size();
        end
        len = ((len + NIB_W - 1) / NIB_W + 6) * NIB_W; // trailing idle words
        for (int l = 0; l < NUM_LANES; l++) begin
            while (lane_q[l].size() < len) lane_q[l].push_back(1'b0);
        end
        for (int n = 0; n < len / NIB_W; ) begin
            @(posedge ipclk);
            cyc++;
            if (cyc % 4 == 3) begin
                sns_en <= 1'b0; // enable gap
            end else begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    for (int i = 0; i < NIB_W; i++) begin
                        d[l*NIB_W + (MSB_FIRST ? NIB_W-1-i : i)] = lane_q[l].pop_front();
                    end
                end
                sns_en <= 1'b1;
                sns_d  <= d;
                n++;
            end
        end
        @(posedge ipclk);
        sns_en <= 1'b0;
        sns_d  <= '0;
    endtask

    // zeros at full rate, also clears the decoder bit history
    task automatic drive_idle(input int n);
        repeat (n) begin
            @(posedge ipclk);
            sns_en <= 1'b1;
            sns_d  <= '0;
        end
    endtask

endmodule

// ==== verification/hispi_rx_tb.sv ====
module hispi_rx_tb;
    import hispi_pkg::*;

    localparam int LINE_W   = 8;  // matches the sensor model line
    localparam int GARB_NIB = 60; // nibbles per lane of the garbage stream

    logic                       ipclk;
    logic                       prst;
    logic                       sns_en;
    logic [NUM_LANES*NIB_W-1:0] sns_d;
    logic                       ignore_embedded;
    pixel_t                     pxd;
    logic                       hact;
    logic                       vact;
    logic [11:0]                line_num;
    logic                       line_err;

    logic [31:0] lfsr;
    pixel_t      exp_q [$]; // pixels expected at pxd
    pixel_t      got_q [$]; // pixels seen while hact
    int          errors;
    int          err_base;  // error count when the test began
    int          tests;
    int          err_pulses;
    int          vact_bad;  // hact without vact
    int          busy_cycles;

    hispi_rx_top #(
        .FIFO_DEPTH (8),
        .LANE_WAIT  (16),
        .MSB_FIRST  (1'b0)
    ) u_dut (
        .ipclk           (ipclk),
        .prst            (prst),
        .sns_en          (sns_en),
        .sns_d           (sns_d),
        .ignore_embedded (ignore_embedded),
        .pxd             (pxd),
        .hact            (hact),
        .vact            (vact),
        .line_num        (line_num),
        .line_err        (line_err)
    );

    hispi_sensor_model #(
        .MSB_FIRST (1'b0)
    ) u_model (
        .ipclk  (ipclk),
        .sns_en (sns_en),
        .sns_d  (sns_d)
    );

    initial begin
        ipclk = 1'b0;
        forever #4 ipclk = ~ipclk;
    end

    // outputs sampled mid-cycle
    always @(negedge ipclk) begin
        if (!prst) begin
            if (hact) got_q.push_back(pxd);
            if (line_err) err_pulses++;
            if (hact && !vact) vact_bad++;
            if (hact || vact || line_err) busy_cycles++;
        end
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic pixel_t rand_pixel();
        pixel_t p;
        p = pixel_t'(rand_bits(WORD_W));
        if (p == 12'hFFF) p = 12'h5A5; // all ones would look like a sync word
        return p;
    endfunction

    // nibbles over all lanes for one frame, lead in and tail included
    function automatic int frame_nibbles(input int lines);
        return NUM_LANES * (lines * (8 + LINE_W / NUM_LANES) * (WORD_W / NIB_W) + 40);
    endfunction

    task automatic compare_pixel(input string name, input pixel_t exp, input pixel_t got);
        if (got !== exp) begin
            $display("** Error %s: pixel expected %h, actual %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic compare_count(input string name, input logic [11:0] exp,
                                 input logic [11:0] got);
        if (got !== exp) begin
            $display("** Error %s: expected %0d, actual %0d", name, exp, got);
            errors++;
        end
    endtask

    task automatic start_test(input bit ign);
        exp_q.delete();
        got_q.delete();
        u_model.clear();
        ignore_embedded <= ign;
        prst <= 1'b1;
        u_model.drive_idle(16);
        prst <= 1'b0;
        err_pulses  = 0;
        vact_bad    = 0;
        busy_cycles = 0;
        err_base    = errors;
    endtask

    // one frame into the model, expected pixels queued in sensor order
    task automatic build_frame(input int lines, input bit embed_first, input int miss_lane,
                               input int miss_line, input bit skewed);
        pixel_t pix [LINE_W];
        pixel_t sol;
        pixel_t eol;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (skewed) u_model.lead_in(l, int'(rand_bits(3)) % 6, int'(rand_bits(2)));
            else        u_model.lead_in(l, 1, 0);
        end
        for (int ln = 0; ln < lines; ln++) begin
            for (int k = 0; k < LINE_W; k++) pix[k] = rand_pixel();
            sol = (ln == 0) ? 12'h003 : 12'h001;         // sof opens the frame
            if (ln == 0 && embed_first) sol = sol | 12'h100; // embedded data flag
            eol = (ln == lines - 1) ? 12'h007 : 12'h005;   // eof closes it
            u_model.add_line(pix, sol, eol, (ln == miss_line) ? miss_lane : -1);
            if (ln != miss_line && !(ln == 0 && embed_first && ignore_embedded)) begin
                for (int k = 0; k < LINE_W; k++) exp_q.push_back(pix[k]);
            end
        end
    endtask

    task automatic wait_done();
        while (got_q.size() < exp_q.size() || vact) @(posedge ipclk);
        repeat (8) @(posedge ipclk);
    endtask

    task automatic check_run(input string name, input int lines, input int errs);
        if (got_q.size() != exp_q.size()) begin
            $display("%s: %0d pixels came out where %0d were expected",
                     name, got_q.size(), exp_q.size());
            errors++;
        end
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            compare_pixel(name, exp_q[i], got_q[i]);
        end
        compare_count({name, " line_num"}, 12'(lines), line_num);
        compare_count({name, " line_err pulses"}, 12'(errs), 12'(err_pulses));
        compare_count({name, " hact outside vact"}, 12'd0, 12'(vact_bad));
        tests++;
        $display("%s finished with %0d errors", name, errors - err_base);
    endtask

    task automatic run_frame(input string name, input bit ign, input int lines,
                             input bit embed_first, input int miss_lane, input int miss_line,
                             input bit skewed, input int exp_lines, input int exp_errs);
        start_test(ign);
        build_frame(lines, embed_first, miss_lane, miss_line, skewed);
        u_model.play();
        wait_done();
        check_run(name, exp_lines, exp_errs);
    endtask

    task automatic test_reset_state();
        start_test(1'b0);
        u_model.drive_idle(24);
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int i = 0; i < GARB_NIB * NIB_W; i++) u_model.add_bit(l, rand_bits(1) != 0);
        end
        u_model.play();
        repeat (16) @(posedge ipclk);
        compare_count("reset_state busy cycles", 12'd0, 12'(busy_cycles));
        check_run("reset_state", 0, 0);
    endtask

    initial begin
        prst            = 1'b1;
        ignore_embedded = 1'b0;
        lfsr            = 32'h553b;
        errors          = 0;
        err_base        = 0;
        tests           = 0;
        run_frame("one_frame", 1'b0, 2, 1'b0, -1, -1, 1'b0, 2, 0);
        run_frame("lane_skew", 1'b0, 2, 1'b0, -1, -1, 1'b1, 2, 0);
        run_frame("embedded_kept", 1'b0, 2, 1'b1, -1, -1, 1'b0, 2, 0);
        run_frame("embedded_dropped", 1'b1, 2, 1'b1, -1, -1, 1'b0, 1, 0);
        run_frame("missing_lane", 1'b0, 3, 1'b0, 2, 1, 1'b0, 2, 1);
        test_reset_state();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // limit from the stream length of every test
    initial begin
        int limit;
        limit = 40 * (4 * frame_nibbles(2) + frame_nibbles(3) + NUM_LANES * GARB_NIB);
        repeat (limit) @(posedge ipclk);
        $display("watchdog: run did not finish within %0d cycles", limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== list.f ====
logic/hispi_pkg.sv
logic/hispi_word_if.sv
logic/hispi_lane_decoder.sv
logic/hispi_line_fifo.sv
logic/hispi_lane_merge.sv
logic/hispi_pixel_out.sv
logic/hispi_rx_top.sv
verification/hispi_sensor_model.sv
verification/hispi_rx_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module hispi_rx_tb -f list.f -o hispi_rx_sim

out=$(./obj_dir/hispi_rx_sim)
echo "$out"

# pass only when the pass line is printed
echo "$out" | grep -qx "TEST PASS"
